//--- Makefile
SRCS := list.f $(wildcard include/*.svh verilog/*.sv verif/*.sv)

.PHONY: all run clean

all: obj_dir/Vmem_bridge_tb

obj_dir/Vmem_bridge_tb: $(SRCS)
	verilator --binary --timing --assert --top-module mem_bridge_tb -f list.f

run: obj_dir/Vmem_bridge_tb
	./obj_dir/Vmem_bridge_tb | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

//--- include/mem_bridge_settings.svh
// Shared widths, APB register map and reset values for the memory bridge.
// APB offsets are byte offsets and must fit in MEM_APB_ADDR_W bits.
// Counter width sets the wrap point of every transaction counter.

`ifndef MEM_BRIDGE_SETTINGS_SVH
`define MEM_BRIDGE_SETTINGS_SVH

// Transaction counter width
`define MEM_EV_COUNT_W 16

// APB register address width
`define MEM_APB_ADDR_W 4

// Code-burst length field after reset, seven gives eight beats
`define MEM_CODE_BEATS_M1_RESET 7

// Register offsets
`define MEM_REG_CTRL       'h0
`define MEM_REG_WR_COUNT   'h4
`define MEM_REG_RD_COUNT   'h8
`define MEM_REG_CODE_COUNT 'hC

`endif

//--- list.f
+incdir+include
verilog/mem_bridge_pkg.sv
verilog/avalon_burst_master.sv
verilog/mem_bridge_regs.sv
verilog/mem_bridge_top.sv
verif/mem_bridge_assert.sv
verif/mem_bridge_tb.sv

//--- verif/mem_bridge_assert.sv
// Avalon and requester protocol rules for the burst master.
// Sampled on the rising edge, ignored while reset is low.

`timescale 1ns/1ps
`default_nettype none

module mem_bridge_assert
   import mem_bridge_pkg::*;
(
   input logic       clk,
   input logic       rst_n,
   input logic       avm_read,
   input logic       avm_write,
   input logic       avm_waitrequest,
   input word_addr_t avm_address,
   input logic       writeburst_done,
   input logic       readburst_done,
   input logic       readcode_done
);

   // Never read and write at once
   no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
      !(avm_read && avm_write))
      else $error("avm_read and avm_write high together");

   // Command held under back-pressure
   hold_cmd: assert property (@(posedge clk) disable iff (!rst_n)
      (avm_read || avm_write) && avm_waitrequest |=>
         $stable(avm_read) && $stable(avm_write) && $stable(avm_address))
      else $error("command changed while waitrequest high");

   // One requester served per cycle
   one_done: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({writeburst_done, readburst_done, readcode_done}))
      else $error("more than one done signal high");

endmodule

bind avalon_burst_master mem_bridge_assert u_assert (.*);

`default_nettype wire

//--- verif/mem_bridge_tb.sv
// Testbench for the memory bridge, with an Avalon slave memory model.
// Slave waitrequest and read gaps come from an xorshift generator.
// Inputs change on the falling edge, outputs sampled on the rising edge.
// APB offsets are 4 bits wide, so the bad offset used is 0xE.

`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_settings.svh"

module mem_bridge_tb
   import mem_bridge_pkg::*;
();

   localparam int N       = 7;
   localparam int TIMEOUT = 200;
   localparam int KW      = 0;
   localparam int KR      = 1;
   localparam int KC      = 2;

   logic clk;
   logic rst_n;
   logic writeburst_do, writeburst_done;
   mem_addr_t writeburst_address;
   dword_len_t writeburst_dword_length;
   byte_en_t writeburst_byteenable_0, writeburst_byteenable_1;
   logic [55:0] writeburst_data;
   logic readburst_do, readburst_done;
   mem_addr_t readburst_address;
   dword_len_t readburst_dword_length;
   byte_len_t readburst_byte_length;
   logic [95:0] readburst_data;
   logic readcode_do, readcode_done;
   mem_addr_t readcode_address;
   dword_t readcode_partial;
   word_addr_t avm_address;
   dword_t avm_writedata;
   byte_en_t avm_byteenable;
   burst_cnt_t avm_burstcount;
   logic avm_write, avm_read;
   logic avm_waitrequest = 1'b0;
   logic avm_readdatavalid = 1'b0;
   dword_t avm_readdata = '0;
   apb_addr_t paddr;
   logic psel, penable, pwrite, pready, pslverr;
   dword_t pwdata, prdata;

   // Slave model state
   dword_t mem [256];
   dword_t shadow [256];
   logic [31:0] rng = 32'h06b5_f584;
   logic [7:0] rd_addr;
   int rd_left;
   byte_en_t cmd_be;
   burst_cnt_t cmd_bc;

   // Stimulus table
   int kind [N];
   mem_addr_t t_addr [N];
   dword_len_t t_dlen [N];
   byte_len_t t_blen [N];
   byte_en_t t_be0 [N];
   byte_en_t t_be1 [N];
   logic [55:0] t_data [N];
   beat_idx_t t_field [N];

   int value_errors = 0;
   int other_errors = 0;

   mem_bridge_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic dword_t fill_word(input int i);
      return {8'hc3 ^ 8'(i), 8'(i), ~8'(i), 8'(i) ^ 8'h96};
   endfunction

   function automatic dword_t merge_lanes(input dword_t old, input dword_t d, input byte_en_t be);
      dword_t r;
      r = old;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            r[b*8 +: 8] = d[b*8 +: 8];
         end
      end
      return r;
   endfunction

   // Lanes from the address lane up, all lanes if the span leaves the dword
   function automatic byte_en_t first_lanes(input byte_len_t bl, input logic [1:0] lane);
      logic [7:0] wide;
      if (bl == 4'd0 || bl > 4'd3) begin
         return 4'b1111;
      end
      wide = ((8'd1 << bl) - 8'd1) << lane;
      return (wide[7:4] != 4'd0) ? 4'b1111 : wide[3:0];
   endfunction

   // --------------------------------------------------
   // Avalon slave memory
   // --------------------------------------------------
   always @(posedge clk) begin
      if (!rst_n) begin
         rd_left <= 0;
         for (int i = 0; i < 256; i++) begin
            mem[i] <= fill_word(i);
         end
      end else begin
         if (avm_readdatavalid) begin
            rd_addr <= rd_addr + 8'd1;
            rd_left <= rd_left - 1;
         end
         if (avm_write && !avm_waitrequest) begin
            mem[avm_address[7:0]] <= merge_lanes(mem[avm_address[7:0]], avm_writedata,
                                                 avm_byteenable);
            cmd_be <= avm_byteenable;
            cmd_bc <= avm_burstcount;
         end
         if (avm_read && !avm_waitrequest) begin
            rd_addr <= avm_address[7:0];
            rd_left <= int'(avm_burstcount);
            cmd_be  <= avm_byteenable;
            cmd_bc  <= avm_burstcount;
         end
      end
   end

   always @(negedge clk) begin
      rng = xorshift(rng);
      avm_waitrequest   = (rng[1:0] == 2'd0);
      avm_readdatavalid = (rd_left != 0) && (rng[3:2] != 2'd0);
      avm_readdata      = mem[rd_addr];
   end

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   task automatic check_dword(input string name, input dword_t got, input dword_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("error %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_data96(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
      if (got !== exp) begin
         value_errors++;
         $display("error %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_be(input string name, input byte_en_t got, input byte_en_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("error %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_burst(input string name, input burst_cnt_t got, input burst_cnt_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("error %0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input ev_count_t got, input ev_count_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("error %0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic report_other(input string msg);
      other_errors++;
      $display("At %0t: %s", $time, msg);
   endtask

   task automatic abort_on_timeout(input string msg);
      report_other(msg);
      $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   // --------------------------------------------------
   // APB access, zero wait states
   // --------------------------------------------------
   task automatic apb_write(input apb_addr_t a, input dword_t d, output logic err);
      @(negedge clk);
      paddr   = a;
      pwdata  = d;
      pwrite  = 1'b1;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      err = pslverr;
      if (pready !== 1'b1) begin
         report_other("pready was low in an APB write access cycle");
      end
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t a, output dword_t d, output logic err);
      @(negedge clk);
      paddr   = a;
      pwrite  = 1'b0;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      d   = prdata;
      err = pslverr;
      if (pready !== 1'b1) begin
         report_other("pready was low in an APB read access cycle");
      end
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic set_entry(input int i, input int k, input mem_addr_t a, input dword_len_t dl,
                            input byte_len_t bl, input byte_en_t b0, input byte_en_t b1,
                            input logic [55:0] d, input beat_idx_t f);
      kind[i]    = k;
      t_addr[i]  = a;
      t_dlen[i]  = dl;
      t_blen[i]  = bl;
      t_be0[i]   = b0;
      t_be1[i]   = b1;
      t_data[i]  = d;
      t_field[i] = f;
   endtask

   function automatic logic [95:0] expected_read(input logic [7:0] idx, input dword_len_t dl);
      dword_t w0;
      dword_t w1;
      dword_t w2;
      w0 = shadow[idx];
      w1 = shadow[idx + 8'd1];
      w2 = shadow[idx + 8'd2];
      case (dl)
         2'd1:    return {w0, w0, w0};
         2'd2:    return {w1, w1, w0};
         default: return {w2, w1, w0};
      endcase
   endfunction

   // --------------------------------------------------
   // One table entry
   // --------------------------------------------------
   task automatic run_entry(input int i);
      logic [7:0] idx;
      logic err;
      logic seen;
      int k;
      int t;
      idx  = t_addr[i][9:2];
      seen = 1'b0;
      k    = 0;
      t    = 0;
      if (kind[i] == KC) begin
         apb_write(`MEM_REG_CTRL, {28'd0, t_field[i], 1'b1}, err);
      end
      @(negedge clk);
      if (kind[i] == KW) begin
         writeburst_address      = t_addr[i];
         writeburst_dword_length = t_dlen[i];
         writeburst_byteenable_0 = t_be0[i];
         writeburst_byteenable_1 = t_be1[i];
         writeburst_data         = t_data[i];
         writeburst_do           = 1'b1;
         shadow[idx] = merge_lanes(shadow[idx], t_data[i][31:0], t_be0[i]);
         if (t_dlen[i] == 2'd2) begin
            shadow[idx + 8'd1] = merge_lanes(shadow[idx + 8'd1], {8'd0, t_data[i][55:32]},
                                             t_be1[i]);
         end
      end else if (kind[i] == KR) begin
         readburst_address      = t_addr[i];
         readburst_dword_length = t_dlen[i];
         readburst_byte_length  = t_blen[i];
         readburst_do           = 1'b1;
      end else begin
         readcode_address = t_addr[i];
         readcode_do      = 1'b1;
      end
      while (!seen && t < TIMEOUT) begin
         @(posedge clk);
         t++;
         if (kind[i] == KC && avm_readdatavalid) begin
            check_dword("readcode_partial", readcode_partial, shadow[idx + 8'(k)]);
            k++;
         end
         if (kind[i] == KW && writeburst_done) begin
            seen = 1'b1;
         end
         if (kind[i] == KR && readburst_done) begin
            seen = 1'b1;
            check_data96("readburst_data", readburst_data, expected_read(idx, t_dlen[i]));
         end
         if (kind[i] == KC && readcode_done) begin
            seen = 1'b1;
         end
      end
      if (!seen) begin
         abort_on_timeout("no done signal for a table request");
      end
      @(negedge clk);
      writeburst_do = 1'b0;
      readburst_do  = 1'b0;
      readcode_do   = 1'b0;
      if (kind[i] == KW) begin
         check_be("avm_byteenable", cmd_be, t_be0[i]);
         check_burst("avm_burstcount", cmd_bc, burst_cnt_t'(t_dlen[i]));
      end else if (kind[i] == KR) begin
         check_be("avm_byteenable", cmd_be, first_lanes(t_blen[i], t_addr[i][1:0]));
         check_burst("avm_burstcount", cmd_bc, burst_cnt_t'(t_dlen[i]));
      end else begin
         check_burst("avm_burstcount", cmd_bc, burst_cnt_t'(t_field[i] + 1));
         check_burst("code beats", burst_cnt_t'(k), burst_cnt_t'(t_field[i] + 1));
      end
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial begin
      int t;
      int order [$];
      logic got_w;
      logic got_r;
      logic got_c;
      logic err;
      dword_t d;
      rst_n = 1'b0;
      writeburst_do = 1'b0;
      writeburst_address = '0;
      writeburst_dword_length = '0;
      writeburst_byteenable_0 = '0;
      writeburst_byteenable_1 = '0;
      writeburst_data = '0;
      readburst_do = 1'b0;
      readburst_address = '0;
      readburst_dword_length = '0;
      readburst_byte_length = '0;
      readcode_do = 1'b0;
      readcode_address = '0;
      paddr = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      pwdata = '0;
      for (int i = 0; i < 256; i++) begin
         shadow[i] = fill_word(i);
      end
      set_entry(0, KW, 32'h40, 2'd1, 4'd0, 4'b0101, 4'b0000, 56'h0_00000_a1b2c3d4, 3'd0);
      set_entry(1, KW, 32'h80, 2'd2, 4'd0, 4'b1111, 4'b0110, 56'h123456_89abcdef, 3'd0);
      set_entry(2, KR, 32'h42, 2'd1, 4'd1, 4'b0000, 4'b0000, 56'h0, 3'd0);
      set_entry(3, KR, 32'h83, 2'd2, 4'd2, 4'b0000, 4'b0000, 56'h0, 3'd0);
      set_entry(4, KR, 32'h7d, 2'd3, 4'd3, 4'b0000, 4'b0000, 56'h0, 3'd0);
      set_entry(5, KC, 32'h100, 2'd0, 4'd0, 4'b0000, 4'b0000, 56'h0, 3'd3);
      set_entry(6, KC, 32'h200, 2'd0, 4'd0, 4'b0000, 4'b0000, 56'h0, 3'd7);

      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      @(posedge clk);
      if (avm_read || avm_write || writeburst_done || readburst_done || readcode_done
          || pslverr) begin
         report_other("an output was high right after reset");
      end

      // Disabled bridge ignores pending requests
      apb_read(`MEM_REG_CTRL, d, err);
      check_dword("ctrl", d, 32'h0000_000e);
      @(negedge clk);
      writeburst_dword_length = 2'd1;
      readburst_dword_length  = 2'd1;
      writeburst_do = 1'b1;
      readburst_do  = 1'b1;
      readcode_do   = 1'b1;
      for (t = 0; t < 20; t++) begin
         @(posedge clk);
         if (avm_read || avm_write || writeburst_done || readburst_done || readcode_done) begin
            report_other("command or done seen while disabled");
         end
      end
      @(negedge clk);
      writeburst_do = 1'b0;
      readburst_do  = 1'b0;
      readcode_do   = 1'b0;
      apb_write(`MEM_REG_CTRL, 32'h0000_000f, err);

      for (int i = 0; i < N; i++) begin
         run_entry(i);
      end

      // Simultaneous requests, served write, read, code
      apb_write(`MEM_REG_CTRL, 32'h0000_0007, err);
      @(negedge clk);
      writeburst_address      = 32'h3c0;
      writeburst_dword_length = 2'd1;
      writeburst_byteenable_0 = 4'b1111;
      writeburst_data         = 56'h0_00000_5a5a0f0f;
      readburst_address       = 32'h3c0;
      readburst_dword_length  = 2'd1;
      readburst_byte_length   = 4'd4;
      readcode_address        = 32'h3c0;
      shadow[240] = 32'h5a5a0f0f;
      writeburst_do = 1'b1;
      readburst_do  = 1'b1;
      readcode_do   = 1'b1;
      got_w = 1'b0;
      got_r = 1'b0;
      got_c = 1'b0;
      t = 0;
      while (order.size() < 3 && t < TIMEOUT) begin
         @(posedge clk);
         t++;
         if (writeburst_done) begin
            order.push_back(KW);
            got_w = 1'b1;
         end
         if (readburst_done) begin
            order.push_back(KR);
            got_r = 1'b1;
            check_data96("readburst_data", readburst_data, {3{shadow[240]}});
         end
         if (readcode_done) begin
            order.push_back(KC);
            got_c = 1'b1;
         end
         @(negedge clk);
         if (got_w) writeburst_do = 1'b0;
         if (got_r) readburst_do = 1'b0;
         if (got_c) readcode_do = 1'b0;
      end
      if (order.size() < 3) begin
         abort_on_timeout("simultaneous requests did not all finish");
      end
      if (order[0] != KW || order[1] != KR || order[2] != KC) begin
         report_other("simultaneous requests finished out of priority order");
      end

      // Counters, clear on write, bad offset
      apb_read(`MEM_REG_WR_COUNT, d, err);
      check_count("wr_count", ev_count_t'(d), 16'd3);
      apb_read(`MEM_REG_RD_COUNT, d, err);
      check_count("rd_count", ev_count_t'(d), 16'd4);
      apb_read(`MEM_REG_CODE_COUNT, d, err);
      check_count("code_count", ev_count_t'(d), 16'd3);
      apb_write(`MEM_REG_WR_COUNT, 32'h0, err);
      apb_read(`MEM_REG_WR_COUNT, d, err);
      check_count("wr_count", ev_count_t'(d), 16'd0);
      apb_write(4'he, 32'h0, err);
      if (err !== 1'b1) begin
         report_other("write to an unmapped offset gave no pslverr");
      end
      apb_read(4'he, d, err);
      if (err !== 1'b1) begin
         report_other("read of an unmapped offset gave no pslverr");
      end
      apb_read(`MEM_REG_CTRL, d, err);
      check_dword("ctrl", d, 32'h0000_0007);
      apb_read(`MEM_REG_RD_COUNT, d, err);
      check_count("rd_count", ev_count_t'(d), 16'd4);
      apb_read(`MEM_REG_CODE_COUNT, d, err);
      check_count("code_count", ev_count_t'(d), 16'd3);

      for (int i = 0; i < 256; i++) begin
         check_dword("mem", mem[i], shadow[i]);
      end

      $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/avalon_burst_master.sv
// Avalon-MM burst master shared by write, read and code requesters.
// Fixed priority in IDLE: write, then read, then code.
// One transaction at a time, no pipelined commands.
// Slave must return read data in order and never signal errors.
// Requesters hold do and arguments steady until their done pulse.

`timescale 1ns/1ps
`default_nettype none

module avalon_burst_master
   import mem_bridge_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,

   input  logic          enable,
   input  beat_idx_t     code_beats_m1,

   input  logic          writeburst_do,
   output logic          writeburst_done,
   input  mem_addr_t     writeburst_address,
   input  dword_len_t    writeburst_dword_length,
   input  byte_en_t      writeburst_byteenable_0,
   input  byte_en_t      writeburst_byteenable_1,
   input  logic [55:0]   writeburst_data,

   input  logic          readburst_do,
   output logic          readburst_done,
   input  mem_addr_t     readburst_address,
   input  dword_len_t    readburst_dword_length,
   input  byte_len_t     readburst_byte_length,
   output logic [95:0]   readburst_data,

   input  logic          readcode_do,
   output logic          readcode_done,
   input  mem_addr_t     readcode_address,
   output dword_t        readcode_partial,

   output word_addr_t    avm_address,
   output dword_t        avm_writedata,
   output byte_en_t      avm_byteenable,
   output burst_cnt_t    avm_burstcount,
   output logic          avm_write,
   output logic          avm_read,
   input  logic          avm_waitrequest,
   input  logic          avm_readdatavalid,
   input  dword_t        avm_readdata
);

   // --------------------------------------------------
   // State and saved beats
   // --------------------------------------------------
   bridge_state_t state;
   beat_idx_t     beats_left;

   // Second write beat, captured when the first is accepted
   word_addr_t    wr_addr_next;
   dword_t        wr_data_next;
   byte_en_t      wr_be_next;

   // Read burst length and earlier beats
   dword_len_t    rd_len_q;
   dword_t        rd_word_0;
   dword_t        rd_word_1;

   byte_en_t      rd_first_be;
   logic          idle_ok;
   logic          start_write;
   logic          start_read;
   logic          start_code;

   // --------------------------------------------------
   // Request selection
   // --------------------------------------------------
   // No new command while disabled
   assign idle_ok     = enable && (state == IDLE);
   assign start_write = idle_ok && writeburst_do;
   assign start_read  = idle_ok && !writeburst_do && readburst_do;
   assign start_code  = idle_ok && !writeburst_do && !readburst_do && readcode_do;

   // First-beat lanes from byte length and address lane
   // Spans that cross the dword use all lanes
   always_comb begin
      case (readburst_byte_length)
         4'd1: rd_first_be = 4'b0001 << readburst_address[1:0];
         4'd2: begin
            if (readburst_address[1:0] != 2'd3) begin
               rd_first_be = 4'b0011 << readburst_address[1:0];
            end else begin
               rd_first_be = 4'b1111;
            end
         end
         4'd3: begin
            if (readburst_address[1:0] <= 2'd1) begin
               rd_first_be = 4'b0111 << readburst_address[1:0];
            end else begin
               rd_first_be = 4'b1111;
            end
         end
         default: rd_first_be = 4'b1111;
      endcase
   end

   // --------------------------------------------------
   // Avalon command outputs
   // --------------------------------------------------
   assign avm_write = start_write || (state == WRITE);
   assign avm_read  = start_read || start_code;

   always_comb begin
      if (start_write) begin
         avm_address = writeburst_address[31:2];
      end else if (state == WRITE) begin
         avm_address = wr_addr_next;
      end else if (start_read) begin
         avm_address = readburst_address[31:2];
      end else begin
         avm_address = readcode_address[31:2];
      end
   end

   assign avm_writedata = (state == WRITE) ? wr_data_next : writeburst_data[31:0];

   always_comb begin
      if (start_write) begin
         avm_byteenable = writeburst_byteenable_0;
      end else if (state == WRITE) begin
         avm_byteenable = wr_be_next;
      end else if (start_read) begin
         avm_byteenable = rd_first_be;
      end else begin
         avm_byteenable = 4'b1111;
      end
   end

   // WRITE state is only reached by two-dword bursts
   always_comb begin
      if (start_write) begin
         avm_burstcount = {2'b00, writeburst_dword_length};
      end else if (state == WRITE) begin
         avm_burstcount = 4'd2;
      end else if (start_read) begin
         avm_burstcount = {2'b00, readburst_dword_length};
      end else begin
         avm_burstcount = {1'b0, code_beats_m1} + 4'd1;
      end
   end

   // --------------------------------------------------
   // Requester side
   // --------------------------------------------------
   assign writeburst_done = start_write && !avm_waitrequest;
   assign readburst_done  = (state == READ) && avm_readdatavalid && (beats_left == 3'd0);
   assign readcode_done   = (state == READ_CODE) && avm_readdatavalid && (beats_left == 3'd0);

   // Code beats go straight through
   assign readcode_partial = avm_readdata;

   // Short bursts replicate the last word into the upper dwords
   always_comb begin
      case (rd_len_q)
         2'd1:    readburst_data = {avm_readdata, avm_readdata, avm_readdata};
         2'd2:    readburst_data = {avm_readdata, avm_readdata, rd_word_0};
         default: readburst_data = {avm_readdata, rd_word_0, rd_word_1};
      endcase
   end

   // --------------------------------------------------
   // FSM
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= IDLE;
         beats_left <= '0;
      end else begin
         case (state)
            IDLE: begin
               // Stall in place under waitrequest
               if (!avm_waitrequest) begin
                  if (start_write) begin
                     if (writeburst_dword_length > 2'd1) begin
                        state <= WRITE;
                     end
                  end else if (start_read) begin
                     state      <= READ;
                     beats_left <= {1'b0, readburst_dword_length} - 3'd1;
                  end else if (start_code) begin
                     state      <= READ_CODE;
                     beats_left <= code_beats_m1;
                  end
               end
            end
            WRITE: begin
               if (!avm_waitrequest) begin
                  state <= IDLE;
               end
            end
            READ, READ_CODE: begin
               if (avm_readdatavalid) begin
                  beats_left <= beats_left - 3'd1;
                  if (beats_left == 3'd0) begin
                     state <= IDLE;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Payload capture
   always_ff @(posedge clk) begin
      if (start_write && !avm_waitrequest) begin
         wr_addr_next <= writeburst_address[31:2] + 30'd1;
         wr_data_next <= {8'd0, writeburst_data[55:32]};
         wr_be_next   <= writeburst_byteenable_1;
      end
      if (start_read && !avm_waitrequest) begin
         rd_len_q <= readburst_dword_length;
      end
      // Beat order: first into word_1 for three, word_0 otherwise
      if ((state == READ) && avm_readdatavalid) begin
         if (beats_left == 3'd2) begin
            rd_word_1 <= avm_readdata;
         end
         if (beats_left == 3'd1) begin
            rd_word_0 <= avm_readdata;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/mem_bridge_pkg.sv
// Types shared by the bridge RTL and its testbench.
// Widths of the counter and APB address come from the settings header.

`default_nettype none

`include "mem_bridge_settings.svh"

package mem_bridge_pkg;

   // Bus and request widths
   typedef logic [31:0] mem_addr_t;
   typedef logic [29:0] word_addr_t;
   typedef logic [31:0] dword_t;
   typedef logic [3:0]  byte_en_t;
   typedef logic [3:0]  burst_cnt_t;
   typedef logic [1:0]  dword_len_t;
   typedef logic [3:0]  byte_len_t;

   // Remaining beats, also the code-burst length minus one
   typedef logic [2:0]  beat_idx_t;

   // Register side
   typedef logic [`MEM_EV_COUNT_W-1:0] ev_count_t;
   typedef logic [`MEM_APB_ADDR_W-1:0] apb_addr_t;

   // Bridge FSM
   typedef enum logic [1:0] {IDLE, WRITE, READ, READ_CODE} bridge_state_t;

endpackage

`default_nettype wire

//--- verilog/mem_bridge_regs.sv
// APB register block for the memory bridge, zero wait states.
// CTRL holds enable and the code-burst length field.
// Counters are read-only, wrap, and clear on any write.
// Offsets other than the four registers answer with pslverr.

`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_settings.svh"

module mem_bridge_regs
   import mem_bridge_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,

   input  apb_addr_t  paddr,
   input  logic       psel,
   input  logic       penable,
   input  logic       pwrite,
   input  dword_t     pwdata,
   output dword_t     prdata,
   output logic       pready,
   output logic       pslverr,

   input  logic       wr_done,
   input  logic       rd_done,
   input  logic       code_done,

   output logic       enable,
   output beat_idx_t  code_beats_m1
);

   logic       access;
   logic       wr_en;
   logic       hit_ctrl;
   logic       hit_wr;
   logic       hit_rd;
   logic       hit_code;
   ev_count_t  wr_count;
   ev_count_t  rd_count;
   ev_count_t  code_count;

   // Clear has priority over a same-cycle done pulse
   function automatic ev_count_t next_count(input ev_count_t cnt, input logic clr,
                                            input logic inc);
      if (clr) begin
         return '0;
      end
      return inc ? cnt + 1'b1 : cnt;
   endfunction

   // --------------------------------------------------
   // Decode
   // --------------------------------------------------
   assign access   = psel && penable;
   assign wr_en    = access && pwrite;
   assign hit_ctrl = (paddr == apb_addr_t'(`MEM_REG_CTRL));
   assign hit_wr   = (paddr == apb_addr_t'(`MEM_REG_WR_COUNT));
   assign hit_rd   = (paddr == apb_addr_t'(`MEM_REG_RD_COUNT));
   assign hit_code = (paddr == apb_addr_t'(`MEM_REG_CODE_COUNT));

   assign pready  = 1'b1;
   assign pslverr = access && !(hit_ctrl || hit_wr || hit_rd || hit_code);

   // Read mux, valid in the access cycle
   always_comb begin
      prdata = '0;
      if (hit_ctrl) begin
         prdata = {28'd0, code_beats_m1, enable};
      end else if (hit_wr) begin
         prdata = dword_t'(wr_count);
      end else if (hit_rd) begin
         prdata = dword_t'(rd_count);
      end else if (hit_code) begin
         prdata = dword_t'(code_count);
      end
   end

   // --------------------------------------------------
   // Registers
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         enable        <= 1'b0;
         code_beats_m1 <= beat_idx_t'(`MEM_CODE_BEATS_M1_RESET);
         wr_count      <= '0;
         rd_count      <= '0;
         code_count    <= '0;
      end else begin
         if (wr_en && hit_ctrl) begin
            enable        <= pwdata[0];
            code_beats_m1 <= pwdata[3:1];
         end
         wr_count   <= next_count(wr_count, wr_en && hit_wr, wr_done);
         rd_count   <= next_count(rd_count, wr_en && hit_rd, rd_done);
         code_count <= next_count(code_count, wr_en && hit_code, code_done);
      end
   end

endmodule

`default_nettype wire

//--- verilog/mem_bridge_top.sv
// Memory bridge top: APB register block beside the Avalon burst master.
// Done pulses feed both the requesters and the transaction counters.

`timescale 1ns/1ps
`default_nettype none

module mem_bridge_top
   import mem_bridge_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,

   // Write requester
   input  logic          writeburst_do,
   output logic          writeburst_done,
   input  mem_addr_t     writeburst_address,
   input  dword_len_t    writeburst_dword_length,
   input  byte_en_t      writeburst_byteenable_0,
   input  byte_en_t      writeburst_byteenable_1,
   input  logic [55:0]   writeburst_data,

   // Read requester
   input  logic          readburst_do,
   output logic          readburst_done,
   input  mem_addr_t     readburst_address,
   input  dword_len_t    readburst_dword_length,
   input  byte_len_t     readburst_byte_length,
   output logic [95:0]   readburst_data,

   // Code requester
   input  logic          readcode_do,
   output logic          readcode_done,
   input  mem_addr_t     readcode_address,
   output dword_t        readcode_partial,

   // Avalon master
   output word_addr_t    avm_address,
   output dword_t        avm_writedata,
   output byte_en_t      avm_byteenable,
   output burst_cnt_t    avm_burstcount,
   output logic          avm_write,
   output logic          avm_read,
   input  logic          avm_waitrequest,
   input  logic          avm_readdatavalid,
   input  dword_t        avm_readdata,

   // APB slave
   input  apb_addr_t     paddr,
   input  logic          psel,
   input  logic          penable,
   input  logic          pwrite,
   input  dword_t        pwdata,
   output dword_t        prdata,
   output logic          pready,
   output logic          pslverr
);

   // Control from the register block
   logic      enable;
   beat_idx_t code_beats_m1;

   mem_bridge_regs u_regs (
      .wr_done   (writeburst_done),
      .rd_done   (readburst_done),
      .code_done (readcode_done),
      .*
   );

   // Requester, Avalon and control ports match by name
   avalon_burst_master u_master (.*);

endmodule

`default_nettype wire
